// File: design/mm2s_settings.svh
`ifndef MM2S_SETTINGS_SVH
`define MM2S_SETTINGS_SVH

`define MM2S_PIX_W 8
`define MM2S_DATA_W 32
`define MM2S_ADDR_W 32

`define MM2S_WBITS 12
`define MM2S_HBITS 12

`define MM2S_BURST_LEN 16
// line stride in memory is 2**MM2S_STRIDE_BITS bytes
`define MM2S_STRIDE_BITS 10
`define MM2S_WORD_PIX 4

// word address of a line bank, MM2S_WBITS less log2(MM2S_WORD_PIX)
`define MM2S_WADDR_W 10
// pixel offset inside one 64-byte burst
`define MM2S_OFF_W 6

`endif

// File: design/mem_pkg.sv
`include "mm2s_settings.svh"

package mem_pkg;

	// len holds the beat count minus one
	typedef struct packed {
		logic [`MM2S_ADDR_W-1:0] addr;
		logic [7:0] len;
	} ar_req_t;

	typedef struct packed {
		logic [`MM2S_DATA_W-1:0] data;
		logic last;
	} r_beat_t;

endpackage

// File: design/video_pkg.sv
`include "mm2s_settings.svh"

package video_pkg;

	typedef logic [`MM2S_HBITS-1:0] row_t;
	typedef logic [`MM2S_WBITS-1:0] col_t;

	typedef struct packed {
		logic [`MM2S_ADDR_W-1:0] frame_addr;
		col_t win_left;
		col_t win_width;
		row_t win_top;
		row_t win_height;
		col_t dst_width;
		row_t dst_height;
	} frame_cfg_t;

	// one source line, fetched from a burst-aligned address
	typedef struct packed {
		logic [`MM2S_ADDR_W-1:0] line_addr;
		logic [`MM2S_WBITS-1:0] words;
		logic [`MM2S_OFF_W-1:0] offset;
	} line_job_t;

	typedef struct packed {
		logic [`MM2S_PIX_W-1:0] data;
		logic user;
		logic last;
	} pix_beat_t;

endpackage

// File: design/scale_1d.sv
`timescale 1ns/100ps

module scale_1d #(
	parameter type idx_t = logic [7:0]
) (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  idx_t src_len,
	input  idx_t dst_len,
	output logic out_valid,
	input  logic out_ready,
	output idx_t out_idx,
	output logic out_last
);
	localparam int W = $bits(idx_t);
	localparam int CW = $clog2(W + 1);

	typedef enum logic [1:0] {S_IDLE, S_DIV, S_RUN} state_t;

	state_t st;
	logic [CW-1:0] div_cnt;
	logic [W-1:0] dst_q;
	// holds the dividend first, the quotient once the divide is done
	logic [W-1:0] quo;
	logic [W-1:0] rem;
	logic [W:0] shifted;
	logic [W-1:0] idx_q;
	logic [W-1:0] cnt;
	logic [W-1:0] acc_rem;
	logic [W:0] rem_sum;
	logic carry;
	logic step;

	assign shifted = {rem, quo[W-1]};
	assign rem_sum = {1'b0, acc_rem} + {1'b0, rem};
	assign carry = (rem_sum >= {1'b0, dst_q});
	assign step = out_valid && out_ready;

	assign out_valid = (st == S_RUN);
	assign out_idx = idx_t'(idx_q);
	assign out_last = (cnt == dst_q - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st <= S_IDLE;
			div_cnt <= '0;
		end else if (start) begin
			st <= S_DIV;
			div_cnt <= '0;
		end else if (st == S_DIV) begin
			div_cnt <= div_cnt + 1'b1;
			if (div_cnt == CW'(W - 1))
				st <= S_RUN;
		end else if (step && out_last) begin
			st <= S_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dst_q <= dst_len;
			quo <= src_len;
			rem <= '0;
			idx_q <= '0;
			cnt <= '0;
			acc_rem <= '0;
		end else if (st == S_DIV) begin
			// restoring divide, one quotient bit per cycle
			if (shifted >= {1'b0, dst_q}) begin
				rem <= W'(shifted - {1'b0, dst_q});
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				rem <= shifted[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end else if (step) begin
			// index j is j*q plus the carries out of the remainder sum
			idx_q <= idx_q + quo + W'(carry);
			acc_rem <= carry ? W'(rem_sum - {1'b0, dst_q}) : rem_sum[W-1:0];
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: design/line_bank.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module line_bank (
	input  logic clk,
	input  logic wr_en,
	input  logic [`MM2S_WADDR_W-1:0] wr_addr,
	input  logic [`MM2S_DATA_W-1:0] wr_data,
	input  logic rd_en,
	input  logic [`MM2S_WBITS-1:0] rd_addr,
	output logic [`MM2S_PIX_W-1:0] rd_data
);
	localparam int SEL_W = `MM2S_WBITS - `MM2S_WADDR_W;

	// lane 0 is the low byte of a bus word
	logic [`MM2S_WORD_PIX-1:0][`MM2S_PIX_W-1:0] mem [2**`MM2S_WADDR_W];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr[`MM2S_WBITS-1:SEL_W]][rd_addr[SEL_W-1:0]];
	end

endmodule

// File: design/line_reader.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module line_reader (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  video_pkg::line_job_t job,
	output logic done,
	output logic ar_valid,
	input  logic ar_ready,
	output mem_pkg::ar_req_t ar,
	input  logic r_valid,
	output logic r_ready,
	input  mem_pkg::r_beat_t r,
	output logic wr_en,
	output logic [`MM2S_WADDR_W-1:0] wr_addr,
	output logic [`MM2S_DATA_W-1:0] wr_data
);
	localparam int BL_W = $clog2(`MM2S_BURST_LEN) + 1;
	localparam int BURST_BYTES = `MM2S_BURST_LEN * (`MM2S_DATA_W / 8);

	typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

	state_t st;
	logic [`MM2S_ADDR_W-1:0] addr_q;
	logic [`MM2S_WBITS-1:0] words_left;
	logic [`MM2S_WADDR_W-1:0] wptr;
	logic [BL_W-1:0] blen;
	logic last_burst;
	logic beat;

	// the tail of a line may need a short burst
	assign last_burst = (words_left <= `MM2S_BURST_LEN);
	assign blen = last_burst ? BL_W'(words_left) : BL_W'(`MM2S_BURST_LEN);

	assign ar_valid = (st == S_ADDR);
	assign ar = '{addr: addr_q, len: 8'(blen - 1'b1)};
	assign r_ready = (st == S_DATA);

	assign beat = r_valid && r_ready;
	assign wr_en = beat;
	assign wr_addr = wptr;
	assign wr_data = r.data;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st <= S_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (st)
				S_IDLE: begin
					if (start)
						st <= S_ADDR;
				end
				S_ADDR: begin
					if (ar_ready)
						st <= S_DATA;
				end
				default: begin
					if (beat && r.last) begin
						if (last_burst) begin
							st <= S_IDLE;
							done <= 1'b1;
						end else begin
							st <= S_ADDR;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (st == S_IDLE && start) begin
			addr_q <= job.line_addr;
			words_left <= job.words;
			wptr <= '0;
		end else begin
			if (beat)
				wptr <= wptr + 1'b1;
			if (beat && r.last) begin
				addr_q <= addr_q + BURST_BYTES;
				words_left <= words_left - blen;
			end
		end
	end

endmodule

// File: design/frame_ctrl.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module frame_ctrl (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  video_pkg::frame_cfg_t cfg_in,
	output video_pkg::frame_cfg_t cfg,
	output logic job_start,
	output video_pkg::line_job_t job,
	input  logic reader_done,
	output logic bank_sel,
	output logic line_ready,
	output logic [`MM2S_OFF_W-1:0] line_offset,
	input  logic line_consumed
);
	logic start_d;
	logic row_valid;
	logic row_ready;
	video_pkg::row_t row_idx;
	logic issue;
	logic rd_busy;
	logic draining;
	logic pending;
	logic filled;
	logic bank_free;
	logic handoff;
	logic [`MM2S_HBITS:0] src_line;
	logic [`MM2S_WBITS:0] span;
	logic [`MM2S_WBITS-1:0] left_aligned;
	video_pkg::line_job_t job_next;

	// row scaler runs once the new configuration is in place
	scale_1d #(
		.idx_t(video_pkg::row_t)
	) u_row_scale (
		.clk(clk),
		.resetn(resetn),
		.start(start_d),
		.src_len(cfg.win_height),
		.dst_len(cfg.dst_height),
		.out_valid(row_valid),
		.out_ready(row_ready),
		.out_idx(row_idx),
		.out_last()
	);

	assign src_line = cfg.win_top + row_idx;
	assign left_aligned = {cfg.win_left[`MM2S_WBITS-1:`MM2S_OFF_W], {(`MM2S_OFF_W){1'b0}}};
	assign span = cfg.win_left[`MM2S_OFF_W-1:0] + cfg.win_width + 2'd3;
	assign job_next = '{
		line_addr: cfg.frame_addr + (src_line << `MM2S_STRIDE_BITS) + left_aligned,
		words: {1'b0, span[`MM2S_WBITS:2]},
		offset: cfg.win_left[`MM2S_OFF_W-1:0]
	};

	// a filled bank waits here while the other one is still draining
	assign filled = reader_done || pending;
	assign bank_free = !draining || line_consumed;
	assign handoff = filled && bank_free;

	assign row_ready = !rd_busy && !pending;
	assign issue = row_valid && row_ready;

	always_ff @(posedge clk) begin
		if (fsync)
			cfg <= cfg_in;
		if (issue)
			job <= job_next;
		if (handoff)
			line_offset <= job.offset;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_d <= 1'b0;
			job_start <= 1'b0;
			line_ready <= 1'b0;
			rd_busy <= 1'b0;
			draining <= 1'b0;
			pending <= 1'b0;
			bank_sel <= 1'b0;
		end else begin
			start_d <= fsync;
			if (fsync) begin
				job_start <= 1'b0;
				line_ready <= 1'b0;
				rd_busy <= 1'b0;
				draining <= 1'b0;
				pending <= 1'b0;
				bank_sel <= 1'b0;
			end else begin
				job_start <= issue;
				line_ready <= handoff;
				pending <= filled && !bank_free;
				if (issue)
					rd_busy <= 1'b1;
				else if (reader_done)
					rd_busy <= 1'b0;
				if (handoff) begin
					draining <= 1'b1;
					bank_sel <= ~bank_sel;
				end else if (line_consumed) begin
					draining <= 1'b0;
				end
			end
		end
	end

endmodule

// File: design/stream_out.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module stream_out (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  video_pkg::frame_cfg_t cfg,
	input  logic line_ready,
	input  logic [`MM2S_OFF_W-1:0] line_offset,
	output logic rd_en,
	output logic [`MM2S_WBITS-1:0] rd_addr,
	input  logic [`MM2S_PIX_W-1:0] rd_data0,
	input  logic [`MM2S_PIX_W-1:0] rd_data1,
	output logic line_consumed,
	output logic m_axis_valid,
	input  logic m_axis_ready,
	output video_pkg::pix_beat_t m_axis
);
	logic col_valid;
	logic col_last;
	video_pkg::col_t col_idx;
	logic rd_bank;
	logic user_q;
	logic last_q;
	logic accept;

	scale_1d #(
		.idx_t(video_pkg::col_t)
	) u_col_scale (
		.clk(clk),
		.resetn(resetn),
		.start(line_ready),
		.src_len(cfg.win_width),
		.dst_len(cfg.dst_width),
		.out_valid(col_valid),
		.out_ready(rd_en),
		.out_idx(col_idx),
		.out_last(col_last)
	);

	// the bank read register doubles as the stream data register
	assign rd_en = col_valid && (!m_axis_valid || m_axis_ready);
	assign rd_addr = col_idx + line_offset;
	assign accept = m_axis_valid && m_axis_ready;
	assign m_axis = '{data: rd_bank ? rd_data1 : rd_data0, user: user_q, last: last_q};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_valid <= 1'b0;
			user_q <= 1'b0;
			last_q <= 1'b0;
			rd_bank <= 1'b1;
			line_consumed <= 1'b0;
		end else begin
			line_consumed <= accept && last_q;
			if (rd_en)
				m_axis_valid <= 1'b1;
			else if (m_axis_ready)
				m_axis_valid <= 1'b0;
			if (rd_en)
				last_q <= col_last;
			if (fsync)
				user_q <= 1'b1;
			else if (accept)
				user_q <= 1'b0;
			// first line of a frame lands in bank 0
			if (fsync)
				rd_bank <= 1'b1;
			else if (line_ready)
				rd_bank <= ~rd_bank;
		end
	end

endmodule

// File: design/mm2s_adv.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module mm2s_adv (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic [`MM2S_ADDR_W-1:0] frame_addr,
	input  logic [`MM2S_WBITS-1:0] win_left,
	input  logic [`MM2S_WBITS-1:0] win_width,
	input  logic [`MM2S_HBITS-1:0] win_top,
	input  logic [`MM2S_HBITS-1:0] win_height,
	input  logic [`MM2S_WBITS-1:0] dst_width,
	input  logic [`MM2S_HBITS-1:0] dst_height,
	output logic [`MM2S_ADDR_W-1:0] m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic m_axi_arvalid,
	input  logic m_axi_arready,
	input  logic [`MM2S_DATA_W-1:0] m_axi_rdata,
	input  logic m_axi_rlast,
	input  logic m_axi_rvalid,
	output logic m_axi_rready,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic [`MM2S_PIX_W-1:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast
);
	video_pkg::frame_cfg_t cfg_in;
	video_pkg::frame_cfg_t cfg;
	video_pkg::line_job_t job;
	video_pkg::pix_beat_t pix;
	mem_pkg::ar_req_t ar;
	mem_pkg::r_beat_t r;
	logic job_start;
	logic reader_done;
	logic bank_sel;
	logic line_ready;
	logic line_consumed;
	logic [`MM2S_OFF_W-1:0] line_offset;
	logic wr_en;
	logic [`MM2S_WADDR_W-1:0] wr_addr;
	logic [`MM2S_DATA_W-1:0] wr_data;
	logic rd_en;
	logic [`MM2S_WBITS-1:0] rd_addr;
	logic [`MM2S_PIX_W-1:0] bank_rd_data [2];

	assign cfg_in = '{
		frame_addr: frame_addr,
		win_left: win_left,
		win_width: win_width,
		win_top: win_top,
		win_height: win_height,
		dst_width: dst_width,
		dst_height: dst_height
	};

	assign m_axi_araddr = ar.addr;
	assign m_axi_arlen = ar.len;
	assign r = '{data: m_axi_rdata, last: m_axi_rlast};

	assign m_axis_tdata = pix.data;
	assign m_axis_tuser = pix.user;
	assign m_axis_tlast = pix.last;

	frame_ctrl u_frame_ctrl (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.cfg_in(cfg_in),
		.cfg(cfg),
		.job_start(job_start),
		.job(job),
		.reader_done(reader_done),
		.bank_sel(bank_sel),
		.line_ready(line_ready),
		.line_offset(line_offset),
		.line_consumed(line_consumed)
	);

	line_reader u_line_reader (
		.clk(clk),
		.resetn(resetn),
		.start(job_start),
		.job(job),
		.done(reader_done),
		.ar_valid(m_axi_arvalid),
		.ar_ready(m_axi_arready),
		.ar(ar),
		.r_valid(m_axi_rvalid),
		.r_ready(m_axi_rready),
		.r(r),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	// ping-pong pair, the reader writes the bank picked by bank_sel
	for (genvar i = 0; i < 2; i++) begin : g_bank
		line_bank u_line_bank (
			.clk(clk),
			.wr_en(wr_en && (bank_sel == 1'(i))),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.rd_en(rd_en),
			.rd_addr(rd_addr),
			.rd_data(bank_rd_data[i])
		);
	end

	stream_out u_stream_out (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.cfg(cfg),
		.line_ready(line_ready),
		.line_offset(line_offset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data0(bank_rd_data[0]),
		.rd_data1(bank_rd_data[1]),
		.line_consumed(line_consumed),
		.m_axis_valid(m_axis_tvalid),
		.m_axis_ready(m_axis_tready),
		.m_axis(pix)
	);

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module axi_mem_model (
	input  logic clk,
	input  logic resetn,
	input  logic [`MM2S_ADDR_W-1:0] araddr,
	input  logic [7:0] arlen,
	input  logic arvalid,
	output logic arready,
	output logic [`MM2S_DATA_W-1:0] rdata,
	output logic rlast,
	output logic rvalid,
	input  logic rready
);
	logic arready_q = 1'b0;
	logic rvalid_q = 1'b0;
	logic rlast_q = 1'b0;
	logic [`MM2S_DATA_W-1:0] rdata_q = '0;
	logic busy = 1'b0;
	logic beat_taken = 1'b0;
	logic [`MM2S_ADDR_W-1:0] burst_addr = '0;
	logic [7:0] burst_len = '0;
	logic [7:0] beat_cnt = '0;

	assign arready = arready_q;
	assign rvalid = rvalid_q;
	assign rlast = rlast_q;
	assign rdata = rdata_q;

	// memory content is a hash of the byte address
	function automatic logic [`MM2S_PIX_W-1:0] byte_at(input logic [`MM2S_ADDR_W-1:0] a);
		return `MM2S_PIX_W'(a ^ (a >> 8) ^ 32'h5a);
	endfunction

	function automatic logic [`MM2S_DATA_W-1:0] word_at(input logic [`MM2S_ADDR_W-1:0] a);
		logic [`MM2S_DATA_W-1:0] w;
		w = '0;
		for (int j = 0; j < `MM2S_WORD_PIX; j++)
			w[`MM2S_PIX_W*j +: `MM2S_PIX_W] = byte_at(a + j);
		return w;
	endfunction

	// outputs change on the falling edge, so the handshake at the next rising edge
	// is already known here
	always @(negedge clk) begin
		if (!resetn) begin
			arready_q = 1'b0;
			rvalid_q = 1'b0;
			rlast_q = 1'b0;
			busy = 1'b0;
			beat_taken = 1'b0;
		end else begin
			if (beat_taken) begin
				rvalid_q = 1'b0;
				beat_taken = 1'b0;
				if (rlast_q)
					busy = 1'b0;
				else
					beat_cnt = beat_cnt + 1'b1;
			end
			if (!busy) begin
				arready_q = ($urandom_range(0, 3) == 0);
				if (arvalid && arready_q) begin
					burst_addr = araddr;
					burst_len = arlen;
					beat_cnt = '0;
					busy = 1'b1;
				end
			end else begin
				arready_q = 1'b0;
				// a beat that was offered stays until it is taken
				if (!rvalid_q)
					rvalid_q = ($urandom_range(0, 2) != 0);
				rdata_q = word_at(burst_addr + 4 * beat_cnt);
				rlast_q = (beat_cnt == burst_len);
				beat_taken = rvalid_q && rready;
			end
		end
	end

endmodule

// File: dv/tb_mm2s.sv
`timescale 1ns/100ps
`include "mm2s_settings.svh"

module tb_mm2s;
	localparam int STRIDE = 1 << `MM2S_STRIDE_BITS;
	localparam int BEAT_TIMEOUT = 3000;
	localparam int QUIET_CYCLES = 40;

	logic clk;
	logic resetn;
	logic fsync;
	logic [`MM2S_ADDR_W-1:0] frame_addr;
	logic [`MM2S_WBITS-1:0] win_left;
	logic [`MM2S_WBITS-1:0] win_width;
	logic [`MM2S_HBITS-1:0] win_top;
	logic [`MM2S_HBITS-1:0] win_height;
	logic [`MM2S_WBITS-1:0] dst_width;
	logic [`MM2S_HBITS-1:0] dst_height;
	logic [`MM2S_ADDR_W-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	logic [`MM2S_DATA_W-1:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic tvalid;
	logic tready;
	logic [`MM2S_PIX_W-1:0] tdata;
	logic tuser;
	logic tlast;
	int frame_no;

	mm2s_adv dut0 (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.frame_addr(frame_addr),
		.win_left(win_left),
		.win_width(win_width),
		.win_top(win_top),
		.win_height(win_height),
		.dst_width(dst_width),
		.dst_height(dst_height),
		.m_axi_araddr(araddr),
		.m_axi_arlen(arlen),
		.m_axi_arvalid(arvalid),
		.m_axi_arready(arready),
		.m_axi_rdata(rdata),
		.m_axi_rlast(rlast),
		.m_axi_rvalid(rvalid),
		.m_axi_rready(rready),
		.m_axis_tvalid(tvalid),
		.m_axis_tready(tready),
		.m_axis_tdata(tdata),
		.m_axis_tuser(tuser),
		.m_axis_tlast(tlast)
	);

	axi_mem_model mem0 (
		.clk(clk),
		.resetn(resetn),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
	endtask

	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		return 8'(a ^ (a >> 8) ^ 32'h5a);
	endfunction

	// nearest neighbour: source index is floor(i * src / dst) on both axes
	function automatic logic [7:0] expected_pixel(input video_pkg::frame_cfg_t f,
			input int row, input int col);
		int src_r;
		int src_c;
		logic [31:0] a;
		src_r = (row * int'(f.win_height)) / int'(f.dst_height);
		src_c = (col * int'(f.win_width)) / int'(f.dst_width);
		a = f.frame_addr + 32'((int'(f.win_top) + src_r) * STRIDE + int'(f.win_left) + src_c);
		return mem_byte(a);
	endfunction

	function automatic video_pkg::frame_cfg_t make_cfg(input logic [31:0] addr,
			input int left, input int width, input int top, input int height,
			input int dw, input int dh);
		video_pkg::frame_cfg_t f;
		f.frame_addr = addr;
		f.win_left = video_pkg::col_t'(left);
		f.win_width = video_pkg::col_t'(width);
		f.win_top = video_pkg::row_t'(top);
		f.win_height = video_pkg::row_t'(height);
		f.dst_width = video_pkg::col_t'(dw);
		f.dst_height = video_pkg::row_t'(dh);
		return f;
	endfunction

	function automatic video_pkg::frame_cfg_t random_cfg();
		return make_cfg($urandom_range(0, 255) << 12, $urandom_range(0, 700),
			$urandom_range(1, 120), $urandom_range(0, 40), $urandom_range(1, 16),
			$urandom_range(1, 120), $urandom_range(1, 12));
	endfunction

	task automatic drive_cfg(input video_pkg::frame_cfg_t f);
		frame_addr = f.frame_addr;
		win_left = f.win_left;
		win_width = f.win_width;
		win_top = f.win_top;
		win_height = f.win_height;
		dst_width = f.dst_width;
		dst_height = f.dst_height;
	endtask

	task automatic run_frame(input video_pkg::frame_cfg_t f, input int ready_pct);
		int row;
		int col;
		int idle;
		int seen;
		int total;
		logic stalled;
		logic [7:0] held_data;
		logic held_user;
		logic held_last;
		row = 0;
		col = 0;
		idle = 0;
		seen = 0;
		stalled = 1'b0;
		total = int'(f.dst_width) * int'(f.dst_height);
		frame_no++;
		@(negedge clk);
		drive_cfg(f);
		fsync = 1'b1;
		@(negedge clk);
		fsync = 1'b0;
		// inputs move on once latched
		drive_cfg(random_cfg());
		while (seen < total) begin
			if (stalled) begin
				check_value("m_axis_tvalid", 1, tvalid);
				check_value("m_axis_tdata", held_data, tdata);
				check_value("m_axis_tuser", held_user, tuser);
				check_value("m_axis_tlast", held_last, tlast);
			end
			tready = ($urandom_range(0, 99) < ready_pct);
			stalled = tvalid && !tready;
			held_data = tdata;
			held_user = tuser;
			held_last = tlast;
			if (tvalid && tready) begin
				check_value("m_axis_tdata", expected_pixel(f, row, col), tdata);
				check_value("m_axis_tuser", (row == 0 && col == 0), tuser);
				check_value("m_axis_tlast", (col == int'(f.dst_width) - 1), tlast);
				seen++;
				idle = 0;
				if (col == int'(f.dst_width) - 1) begin
					col = 0;
					row++;
				end else begin
					col++;
				end
			end else begin
				idle++;
				if (idle > BEAT_TIMEOUT)
					fail_run($sformatf("Timeout at %0t: no pixel beat for %0d cycles in frame %0d",
						$time, BEAT_TIMEOUT, frame_no));
			end
			@(negedge clk);
		end
		// after the last row nothing more is fetched or sent
		tready = 1'b1;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			check_value("m_axis_tvalid", 0, tvalid);
			check_value("m_axi_arvalid", 0, arvalid);
		end
	endtask

	initial begin
		void'($urandom(32'h918d_2419));
		clk = 1'b0;
		resetn = 1'b0;
		fsync = 1'b0;
		tready = 1'b0;
		frame_no = 0;
		drive_cfg('0);
		repeat (3) @(negedge clk);
		resetn = 1'b1;

		// unscaled, window starts off word and burst boundaries
		run_frame(make_cfg(32'h0001_0000, 37, 70, 5, 4, 70, 4), 100);
		run_frame(make_cfg(32'h0004_2000, 3, 130, 0, 3, 130, 3), 60);
		// up in both, down in both, then mixed
		run_frame(make_cfg(32'h0002_0000, 100, 20, 7, 5, 53, 11), 70);
		run_frame(make_cfg(32'h0003_1000, 250, 90, 12, 12, 31, 5), 50);
		run_frame(make_cfg(32'h0000_4000, 61, 17, 2, 9, 45, 3), 80);
		run_frame(make_cfg(32'h0005_0000, 513, 100, 30, 2, 7, 9), 40);

		for (int i = 0; i < 8; i++)
			run_frame(random_cfg(), $urandom_range(30, 100));

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/mem_pkg.sv
design/video_pkg.sv
design/scale_1d.sv
design/line_bank.sv
design/line_reader.sv
design/frame_ctrl.sv
design/stream_out.sv
design/mm2s_adv.sv
dv/axi_mem_model.sv
dv/tb_mm2s.sv

// File: Bender.yml
package:
  name: mm2s_adv

sources:
  - include_dirs:
      - design
    files:
      - design/mem_pkg.sv
      - design/video_pkg.sv
      - design/scale_1d.sv
      - design/line_bank.sv
      - design/line_reader.sv
      - design/frame_ctrl.sv
      - design/stream_out.sv
      - design/mm2s_adv.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/axi_mem_model.sv
      - dv/tb_mm2s.sv
